/* design/execPkg.sv */
// ================================================
// Shared widths, opcodes and ALU/branch encodings
// for the 16-bit execute stage. The instruction
// union assumes a fixed 16-bit instruction word.
// ================================================
`default_nettype none

package execPkg;

   localparam int dataW  = 16;
   localparam int opW    = 5;
   localparam int aluOpW = 4;
   localparam int brW    = 3;

   // Opcodes
   localparam logic [opW-1:0] opHalt   = 5'b00000;
   localparam logic [opW-1:0] opNop    = 5'b00001;
   localparam logic [opW-1:0] opJ      = 5'b00100;
   localparam logic [opW-1:0] opJr     = 5'b00101;
   localparam logic [opW-1:0] opAddi   = 5'b01000;
   localparam logic [opW-1:0] opSubi   = 5'b01001;
   localparam logic [opW-1:0] opXori   = 5'b01010;
   localparam logic [opW-1:0] opAndni  = 5'b01011;
   localparam logic [opW-1:0] opBeqz   = 5'b01100;
   localparam logic [opW-1:0] opBnez   = 5'b01101;
   localparam logic [opW-1:0] opBltz   = 5'b01110;
   localparam logic [opW-1:0] opBgez   = 5'b01111;
   localparam logic [opW-1:0] opSt     = 5'b10000;
   localparam logic [opW-1:0] opLd     = 5'b10001;
   localparam logic [opW-1:0] opRoli   = 5'b10100;
   localparam logic [opW-1:0] opSlli   = 5'b10101;
   localparam logic [opW-1:0] opRori   = 5'b10110;
   localparam logic [opW-1:0] opSrli   = 5'b10111;
   localparam logic [opW-1:0] opLbi    = 5'b11000;
   localparam logic [opW-1:0] opShiftR = 5'b11010;
   localparam logic [opW-1:0] opArithR = 5'b11011;

   // R-type func codes, shift group then arithmetic group
   localparam logic [1:0] funcRol  = 2'b00;
   localparam logic [1:0] funcSll  = 2'b01;
   localparam logic [1:0] funcRor  = 2'b10;
   localparam logic [1:0] funcSrl  = 2'b11;
   localparam logic [1:0] funcAdd  = 2'b00;
   localparam logic [1:0] funcSub  = 2'b01;
   localparam logic [1:0] funcXor  = 2'b10;
   localparam logic [1:0] funcAndn = 2'b11;

   // ALU operations
   localparam logic [aluOpW-1:0] aluAdd   = 4'd0;
   localparam logic [aluOpW-1:0] aluSub   = 4'd1;
   localparam logic [aluOpW-1:0] aluXor   = 4'd2;
   localparam logic [aluOpW-1:0] aluAndn  = 4'd3;
   localparam logic [aluOpW-1:0] aluRol   = 4'd4;
   localparam logic [aluOpW-1:0] aluSll   = 4'd5;
   localparam logic [aluOpW-1:0] aluRor   = 4'd6;
   localparam logic [aluOpW-1:0] aluSrl   = 4'd7;
   localparam logic [aluOpW-1:0] aluPassB = 4'd8;

   // Branch codes
   localparam logic [brW-1:0] brNone = 3'd0;
   localparam logic [brW-1:0] brEqz  = 3'd1;
   localparam logic [brW-1:0] brNez  = 3'd2;
   localparam logic [brW-1:0] brLtz  = 3'd3;
   localparam logic [brW-1:0] brGez  = 3'd4;

   typedef struct packed {
      logic [opW-1:0] opcode;
      logic [2:0]     rs;
      logic [2:0]     rt;
      logic [2:0]     rd;
      logic [1:0]     func;
   } rTypeT;

   typedef struct packed {
      logic [opW-1:0] opcode;
      logic [2:0]     rs;
      logic [2:0]     rd;
      logic [4:0]     imm;
   } iTypeT;

   typedef struct packed {
      logic [opW-1:0] opcode;
      logic [2:0]     rs;
      logic [7:0]     imm;
   } bTypeT;

   typedef struct packed {
      logic [opW-1:0] opcode;
      logic [10:0]    disp;
   } jTypeT;

   // Same word, four decodings; opcode sits in the top bits of all of them
   typedef union packed {
      rTypeT rType;
      iTypeT iType;
      bTypeT bType;
      jTypeT jType;
   } instrT;

endpackage

`default_nettype wire

/* design/execCtrlIf.sv */
// ================================================
// Decoded control from the decoder to the execute
// stage. Immediates arrive already extended.
// ================================================
`default_nettype none

interface execCtrlIf #(
   parameter int dataW = execPkg::dataW
);
   import execPkg::*;

   logic [aluOpW-1:0] aluOp;
   logic              useImm;
   logic [dataW-1:0]  immValue;
   logic [dataW-1:0]  branchOffset;
   logic [brW-1:0]    brCode;
   logic              jumpRel;
   logic              jumpReg;
   logic              memRead;
   logic              memWrite;
   logic              halt;

   modport src (
      output aluOp, useImm, immValue, branchOffset, brCode,
      output jumpRel, jumpReg, memRead, memWrite, halt
   );

   modport dst (
      input aluOp, useImm, immValue, branchOffset, brCode,
      input jumpRel, jumpReg, memRead, memWrite, halt
   );

endinterface

`default_nettype wire

/* design/claAdder16.sv */
// ================================================
// 16-bit carry-lookahead adder, four 4-bit groups
// with a second lookahead level across groups.
// ovf is signed overflow of the two inputs.
// ================================================
`default_nettype none

module claAdder16 (
   input  logic [15:0] a,
   input  logic [15:0] b,
   input  logic        cIn,
   output logic [15:0] sum,
   output logic        cOut,
   output logic        ovf
);

   logic [15:0] g;
   logic [15:0] p;
   logic [15:0] c;     // carry into each bit
   logic [3:0]  grpG;
   logic [3:0]  grpP;
   logic [4:0]  grpC;  // carry into each group, grpC[4] is carry out

   assign g = a & b;
   assign p = a ^ b;

   for (genvar k = 0; k < 4; k++) begin : gGrp
      localparam int lo = 4 * k;

      assign c[lo]   = grpC[k];
      assign c[lo+1] = g[lo] | (p[lo] & grpC[k]);
      assign c[lo+2] = g[lo+1] | (p[lo+1] & g[lo])
                     | (p[lo+1] & p[lo] & grpC[k]);
      assign c[lo+3] = g[lo+2] | (p[lo+2] & g[lo+1])
                     | (p[lo+2] & p[lo+1] & g[lo])
                     | (p[lo+2] & p[lo+1] & p[lo] & grpC[k]);

      // Group generate and propagate
      assign grpG[k] = g[lo+3] | (p[lo+3] & g[lo+2])
                     | (p[lo+3] & p[lo+2] & g[lo+1])
                     | (p[lo+3] & p[lo+2] & p[lo+1] & g[lo]);
      assign grpP[k] = &p[lo+3:lo];
   end

   // Second level lookahead
   assign grpC[0] = cIn;
   assign grpC[1] = grpG[0] | (grpP[0] & grpC[0]);
   assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & grpC[0]);
   assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                  | (grpP[2] & grpP[1] & grpP[0] & grpC[0]);
   assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (grpP[3] & grpP[2] & grpG[1])
                  | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                  | (grpP[3] & grpP[2] & grpP[1] & grpP[0] & grpC[0]);

   assign sum  = p ^ c;
   assign cOut = grpC[4];
   // Carry into msb differs from carry out on signed overflow
   assign ovf  = c[15] ^ grpC[4];

endmodule

`default_nettype wire

/* design/alu.sv */
// ================================================
// 16-bit ALU. Subtract is inA - inB. Shift and
// rotate amounts use only inB[3:0]. cf and of are
// meaningful for add and subtract only.
// ================================================
`default_nettype none

module alu (
   input  logic [execPkg::dataW-1:0]  inA,
   input  logic [execPkg::dataW-1:0]  inB,
   input  logic [execPkg::aluOpW-1:0] aluOp,
   output logic [execPkg::dataW-1:0]  result,
   output logic                       zf,
   output logic                       sf,
   output logic                       cf,
   output logic                       of
);
   import execPkg::*;

   logic              isSub;
   logic              invB;
   logic [dataW-1:0]  opB;
   logic [dataW-1:0]  sum;
   logic              cOut;
   logic              ovf;
   logic [3:0]        shAmt;
   logic [2*dataW-1:0] rolWide;
   logic [2*dataW-1:0] rorWide;

   assign isSub = (aluOp == aluSub);
   assign invB  = isSub | (aluOp == aluAndn);
   assign opB   = invB ? ~inB : inB;

   // Two's complement subtract via inverted B plus one
   claAdder16 i_adder (
      .a    (inA),
      .b    (opB),
      .cIn  (isSub),
      .sum  (sum),
      .cOut (cOut),
      .ovf  (ovf)
   );

   assign shAmt = inB[3:0];

   // Rotates shift a doubled copy and keep one half
   assign rolWide = {inA, inA} << shAmt;
   assign rorWide = {inA, inA} >> shAmt;

   always_comb begin
      case (aluOp)
         aluAdd,
         aluSub:   result = sum;
         aluXor:   result = inA ^ inB;
         aluAndn:  result = inA & opB;
         aluRol:   result = rolWide[2*dataW-1:dataW];
         aluSll:   result = inA << shAmt;
         aluRor:   result = rorWide[dataW-1:0];
         aluSrl:   result = inA >> shAmt;
         aluPassB: result = inB;
         default:  result = inB;
      endcase
   end

   // Flags
   assign zf = (result == '0);
   assign sf = result[dataW-1];
   assign cf = cOut;
   assign of = ovf;

endmodule

`default_nettype wire

/* design/branchCond.sv */
// ================================================
// Branch decision from zero and sign flags of
// rs + 0. brNone and unknown codes are not taken.
// ================================================
`default_nettype none

module branchCond (
   input  logic [execPkg::brW-1:0] brCode,
   input  logic                    zf,
   input  logic                    sf,
   output logic                    taken
);
   import execPkg::*;

   always_comb begin
      case (brCode)
         brEqz:   taken = zf;
         brNez:   taken = ~zf;
         brLtz:   taken = sf;
         // Zero counts as non-negative
         brGez:   taken = ~sf;
         default: taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* design/instrDecoder.sv */
// ================================================
// Combinational instruction decoder. Unknown
// opcodes decode as NOP: pass B, no strobes.
// Register operands are read outside this block.
// ================================================
`default_nettype none

module instrDecoder #(
   parameter int dataW = execPkg::dataW
) (
   input  execPkg::instrT instr,
   execCtrlIf.src         ctrl
);
   import execPkg::*;

   logic [dataW-1:0] sImm5;
   logic [dataW-1:0] zImm5;
   logic [dataW-1:0] sImm8;
   logic [dataW-1:0] sDisp11;

   // Immediate extensions from the different views of the word
   assign sImm5   = {{(dataW-5){instr.iType.imm[4]}}, instr.iType.imm};
   assign zImm5   = {{(dataW-5){1'b0}}, instr.iType.imm};
   assign sImm8   = {{(dataW-8){instr.bType.imm[7]}}, instr.bType.imm};
   assign sDisp11 = {{(dataW-11){instr.jType.disp[10]}}, instr.jType.disp};

   always_comb begin
      ctrl.aluOp        = aluPassB;
      ctrl.useImm       = 1'b0;
      ctrl.immValue     = '0;
      ctrl.branchOffset = '0;
      ctrl.brCode       = brNone;
      ctrl.jumpRel      = 1'b0;
      ctrl.jumpReg      = 1'b0;
      ctrl.memRead      = 1'b0;
      ctrl.memWrite     = 1'b0;
      ctrl.halt         = 1'b0;

      case (instr.rType.opcode)
         opHalt: ctrl.halt = 1'b1;
         opJ: begin
            ctrl.jumpRel      = 1'b1;
            ctrl.branchOffset = sDisp11;
         end
         opJr: begin
            // Target is rs + imm8 through the ALU
            ctrl.jumpReg  = 1'b1;
            ctrl.aluOp    = aluAdd;
            ctrl.useImm   = 1'b1;
            ctrl.immValue = sImm8;
         end
         opAddi, opSubi, opSt, opLd: begin
            ctrl.aluOp    = (instr.rType.opcode == opSubi) ? aluSub : aluAdd;
            ctrl.useImm   = 1'b1;
            ctrl.immValue = sImm5;
            ctrl.memWrite = (instr.rType.opcode == opSt);
            ctrl.memRead  = (instr.rType.opcode == opLd);
         end
         opXori, opAndni: begin
            ctrl.aluOp    = (instr.rType.opcode == opXori) ? aluXor : aluAndn;
            ctrl.useImm   = 1'b1;
            ctrl.immValue = zImm5;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            // ALU computes rs + 0 so the flags reflect rs
            ctrl.aluOp        = aluAdd;
            ctrl.useImm       = 1'b1;
            ctrl.branchOffset = sImm8;
            ctrl.brCode       = (instr.rType.opcode == opBeqz) ? brEqz :
                                (instr.rType.opcode == opBnez) ? brNez :
                                (instr.rType.opcode == opBltz) ? brLtz : brGez;
         end
         opRoli, opSlli, opRori, opSrli: begin
            // Low two opcode bits follow the shift func encoding
            ctrl.aluOp    = aluRol + aluOpW'(instr.rType.opcode[1:0]);
            ctrl.useImm   = 1'b1;
            ctrl.immValue = zImm5;
         end
         opLbi: begin
            ctrl.useImm   = 1'b1;
            ctrl.immValue = sImm8;
         end
         opShiftR: ctrl.aluOp = aluRol + aluOpW'(instr.rType.func);
         opArithR: ctrl.aluOp = aluAdd + aluOpW'(instr.rType.func);
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* design/executeStage.sv */
// ================================================
// Execute stage with one register slot. No stall:
// a new item may enter every cycle. Data outputs
// hold during bubbles, strobes drop to zero.
// ================================================
`default_nettype none

module executeStage #(
   parameter int dataW = execPkg::dataW
) (
   input  logic             clk,
   input  logic             arstN,
   input  logic             inValid,
   execCtrlIf.dst           ctrl,
   input  logic [dataW-1:0] rsData,
   input  logic [dataW-1:0] rtData,
   input  logic [dataW-1:0] pc,
   output logic             outValid,
   output logic [dataW-1:0] aluResult,
   output logic [dataW-1:0] nextPc,
   output logic             memRead,
   output logic             memWrite,
   output logic             halt
);

   logic [dataW-1:0] opB;
   logic [dataW-1:0] aluOut;
   logic [dataW-1:0] pcTarget;
   logic [dataW-1:0] nextPcD;
   logic             zf;
   logic             sf;
   logic             brTaken;

   // Operand B mux
   assign opB = ctrl.useImm ? ctrl.immValue : rtData;

   alu i_alu (
      .inA    (rsData),
      .inB    (opB),
      .aluOp  (ctrl.aluOp),
      .result (aluOut),
      .zf     (zf),
      .sf     (sf),
      .cf     (),
      .of     ()
   );

   branchCond i_branchCond (
      .brCode (ctrl.brCode),
      .zf     (zf),
      .sf     (sf),
      .taken  (brTaken)
   );

   // Separate adder for branch and J targets
   claAdder16 i_pcAdder (
      .a    (pc),
      .b    (ctrl.branchOffset),
      .cIn  (1'b0),
      .sum  (pcTarget),
      .cOut (),
      .ovf  ()
   );

   // Halt wins over any jump or branch
   always_comb begin
      if (ctrl.halt) begin
         nextPcD = pc;
      end else if (ctrl.jumpReg) begin
         nextPcD = aluOut;
      end else if (ctrl.jumpRel || brTaken) begin
         nextPcD = pcTarget;
      end else begin
         nextPcD = pc;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         outValid  <= 1'b0;
         memRead   <= 1'b0;
         memWrite  <= 1'b0;
         halt      <= 1'b0;
         aluResult <= '0;
         nextPc    <= '0;
      end else begin
         outValid <= inValid;
         memRead  <= inValid & ctrl.memRead;
         memWrite <= inValid & ctrl.memWrite;
         halt     <= inValid & ctrl.halt;
         // Payload only moves on a valid item
         if (inValid) begin
            aluResult <= aluOut;
            nextPc    <= nextPcD;
         end
      end
   end

endmodule

`default_nettype wire

/* design/execTop.sv */
// ================================================
// Execute top level: decoder plus execute stage.
// One cycle latency, no back-pressure; every
// valid output must be taken by the consumer.
// ================================================
`default_nettype none

module execTop #(
   parameter int dataW = execPkg::dataW
) (
   input  logic             clk,
   input  logic             arstN,
   input  logic             inValid,
   input  logic [dataW-1:0] instr,
   input  logic [dataW-1:0] rsData,
   input  logic [dataW-1:0] rtData,
   input  logic [dataW-1:0] pc,
   output logic             outValid,
   output logic [dataW-1:0] aluResult,
   output logic [dataW-1:0] nextPc,
   output logic             memRead,
   output logic             memWrite,
   output logic             halt
);

   execCtrlIf #(.dataW(dataW)) ctrlIf ();

   instrDecoder #(.dataW(dataW)) i_decoder (
      .instr (instr),
      .ctrl  (ctrlIf.src)
   );

   executeStage #(.dataW(dataW)) i_executeStage (
      .clk       (clk),
      .arstN     (arstN),
      .inValid   (inValid),
      .ctrl      (ctrlIf.dst),
      .rsData    (rsData),
      .rtData    (rtData),
      .pc        (pc),
      .outValid  (outValid),
      .aluResult (aluResult),
      .nextPc    (nextPc),
      .memRead   (memRead),
      .memWrite  (memWrite),
      .halt      (halt)
   );

endmodule

`default_nettype wire

/* verif/tbExec.sv */
// ================================================
// Testbench for execTop. Checks run as concurrent
// assertions sampled on the falling clock edge.
// The expected outputs come from a reference model
// and are held across bubbles like the DUT's.
// ================================================
`default_nettype none

module tbExec;
   import execPkg::*;

   localparam int drainLimit    = 8;
   localparam int watchdogLimit = 5000;

   logic        clk = 1'b0;
   logic        arstN;
   logic        inValid;
   logic [15:0] instr;
   logic [15:0] rsData;
   logic [15:0] rtData;
   logic [15:0] pc;
   logic        outValid;
   logic [15:0] aluResult;
   logic [15:0] nextPc;
   logic        memRead;
   logic        memWrite;
   logic        halt;

   logic        expValid;
   logic [15:0] expAlu;
   logic [15:0] expNpc;
   logic        expMemRead;
   logic        expMemWrite;
   logic        expHalt;
   logic [34:0] refNow;

   int seed      = 14;
   int errCount  = 0;
   int errStart  = 0;
   int testNum   = 0;
   int passCount = 0;
   int failCount = 0;

   // Every defined opcode, for the random test
   logic [4:0] opList [21] = '{opHalt, opNop, opJ, opJr, opAddi, opSubi, opXori,
                               opAndni, opBeqz, opBnez, opBltz, opBgez, opSt, opLd,
                               opRoli, opSlli, opRori, opSrli, opLbi, opShiftR, opArithR};

   execTop #(.dataW(dataW)) i_execTop (
      .clk       (clk),
      .arstN     (arstN),
      .inValid   (inValid),
      .instr     (instr),
      .rsData    (rsData),
      .rtData    (rtData),
      .pc        (pc),
      .outValid  (outValid),
      .aluResult (aluResult),
      .nextPc    (nextPc),
      .memRead   (memRead),
      .memWrite  (memWrite),
      .halt      (halt)
   );

   always #50 clk = ~clk;

   function automatic logic [15:0] r16();
      return 16'($random(seed));
   endfunction

   function automatic logic [15:0] wordR(input logic [4:0] op, input logic [1:0] fn,
                                         input logic [15:0] fill);
      return {op, fill[8:0], fn};
   endfunction

   function automatic logic [15:0] wordI(input logic [4:0] op, input logic [4:0] imm,
                                         input logic [15:0] fill);
      return {op, fill[5:0], imm};
   endfunction

   function automatic logic [15:0] wordB(input logic [4:0] op, input logic [7:0] imm,
                                         input logic [15:0] fill);
      return {op, fill[2:0], imm};
   endfunction

   function automatic logic [15:0] wordJ(input logic [4:0] op, input logic [10:0] disp);
      return {op, disp};
   endfunction

   function automatic logic [15:0] rotl(input logic [15:0] v, input logic [3:0] n);
      return (v << n) | (v >> (16 - n));
   endfunction

   function automatic logic [15:0] rotr(input logic [15:0] v, input logic [3:0] n);
      return (v >> n) | (v << (16 - n));
   endfunction

   // Returns {aluResult, nextPc, memRead, memWrite, halt}
   function automatic logic [34:0] refModel(input logic [15:0] w, input logic [15:0] rs,
                                            input logic [15:0] rt, input logic [15:0] pcIn);
      logic [4:0]  op;
      logic [15:0] s5;
      logic [15:0] z5;
      logic [15:0] s8;
      logic [15:0] s11;
      logic [15:0] res;
      logic [15:0] npc;
      logic        rd;
      logic        wr;
      logic        hl;
      logic        taken;
      op    = w[15:11];
      s5    = {{11{w[4]}}, w[4:0]};
      z5    = {11'b0, w[4:0]};
      s8    = {{8{w[7]}}, w[7:0]};
      s11   = {{5{w[10]}}, w[10:0]};
      res   = rt;
      npc   = pcIn;
      rd    = 1'b0;
      wr    = 1'b0;
      hl    = 1'b0;
      taken = 1'b0;
      case (op)
         opHalt:  hl = 1'b1;
         opJ:     npc = pcIn + s11;
         opJr: begin
            res = rs + s8;
            npc = res;
         end
         opAddi:  res = rs + s5;
         opSubi:  res = rs - s5;
         opXori:  res = rs ^ z5;
         opAndni: res = rs & ~z5;
         opLd: begin
            res = rs + s5;
            rd  = 1'b1;
         end
         opSt: begin
            res = rs + s5;
            wr  = 1'b1;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            res = rs;
            case (op)
               opBeqz:  taken = (rs == 16'h0);
               opBnez:  taken = (rs != 16'h0);
               opBltz:  taken = rs[15];
               default: taken = !rs[15];
            endcase
            if (taken) npc = pcIn + s8;
         end
         opRoli:  res = rotl(rs, w[3:0]);
         opSlli:  res = rs << w[3:0];
         opRori:  res = rotr(rs, w[3:0]);
         opSrli:  res = rs >> w[3:0];
         opLbi:   res = s8;
         opShiftR: begin
            case (w[1:0])
               2'b00:   res = rotl(rs, rt[3:0]);
               2'b01:   res = rs << rt[3:0];
               2'b10:   res = rotr(rs, rt[3:0]);
               default: res = rs >> rt[3:0];
            endcase
         end
         opArithR: begin
            case (w[1:0])
               2'b00:   res = rs + rt;
               2'b01:   res = rs - rt;
               2'b10:   res = rs ^ rt;
               default: res = rs & ~rt;
            endcase
         end
         default: ;
      endcase
      return {res, npc, rd, wr, hl};
   endfunction

   assign refNow = refModel(instr, rsData, rtData, pc);

   // Expected outputs, one cycle behind the inputs
   always @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         expValid    <= 1'b0;
         expMemRead  <= 1'b0;
         expMemWrite <= 1'b0;
         expHalt     <= 1'b0;
         expAlu      <= 16'h0;
         expNpc      <= 16'h0;
      end else begin
         expValid    <= inValid;
         expMemRead  <= inValid & refNow[2];
         expMemWrite <= inValid & refNow[1];
         expHalt     <= inValid & refNow[0];
         if (inValid) begin
            expAlu <= refNow[34:19];
            expNpc <= refNow[18:3];
         end
      end
   end

   task automatic reportMismatch(input string name, input logic [15:0] expV,
                                 input logic [15:0] actV);
      errCount++;
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expV, actV);
   endtask

   task automatic reportFailure(input string what);
      errCount++;
      $display("ERROR at %0t: %s", $time, what);
   endtask

   validCheck: assert property (@(negedge clk) outValid == expValid)
      else reportMismatch("outValid", 16'(expValid), 16'(outValid));
   aluCheck: assert property (@(negedge clk) aluResult == expAlu)
      else reportMismatch("aluResult", expAlu, aluResult);
   npcCheck: assert property (@(negedge clk) nextPc == expNpc)
      else reportMismatch("nextPc", expNpc, nextPc);
   readCheck: assert property (@(negedge clk) memRead == expMemRead)
      else reportMismatch("memRead", 16'(expMemRead), 16'(memRead));
   writeCheck: assert property (@(negedge clk) memWrite == expMemWrite)
      else reportMismatch("memWrite", 16'(expMemWrite), 16'(memWrite));
   haltCheck: assert property (@(negedge clk) halt == expHalt)
      else reportMismatch("halt", 16'(expHalt), 16'(halt));
   resetQuiet: assert property (@(negedge clk) !arstN |-> (!outValid && !memRead
                                && !memWrite && !halt && aluResult == 16'h0
                                && nextPc == 16'h0))
      else reportFailure("outputs are not cleared while reset is asserted");
   bubbleQuiet: assert property (@(negedge clk) !outValid |-> !(memRead || memWrite || halt))
      else reportFailure("a strobe is high while outValid is low");

   task automatic issue(input logic [15:0] w, input logic [15:0] rs, input logic [15:0] rt,
                        input logic [15:0] pcIn, input logic v);
      instr   = w;
      rsData  = rs;
      rtData  = rt;
      pc      = pcIn;
      inValid = v;
      @(posedge clk);
      #1;
   endtask

   task automatic sendRand(input logic [15:0] w);
      issue(w, r16(), r16(), r16(), 1'b1);
   endtask

   // Small positive and negative immediate
   task automatic sendImmPair(input logic [4:0] op);
      sendRand(wordI(op, 5'h06, r16()));
      sendRand(wordI(op, 5'h19, r16()));
   endtask

   // Drain the pipe, then report the test
   task automatic finishTest(input string name);
      int waitCnt;
      waitCnt = 0;
      inValid = 1'b0;
      @(negedge clk);
      while (outValid !== 1'b0 && waitCnt < drainLimit) begin
         @(negedge clk);
         waitCnt++;
      end
      if (outValid !== 1'b0) begin
         reportFailure("outValid did not drop after the last item");
      end
      @(posedge clk);
      #1;
      testNum++;
      if (errCount == errStart) begin
         passCount++;
         $display("test %0d (%s): pass", testNum, name);
      end else begin
         failCount++;
         $display("test %0d (%s): fail, %0d errors", testNum, name, errCount - errStart);
      end
      errStart = errCount;
   endtask

   initial begin
      repeat (watchdogLimit) @(posedge clk);
      $display("Watchdog expired after %0d cycles", watchdogLimit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      logic [4:0]  op;
      logic [15:0] word;
      int          pick;
      arstN   = 1'b0;
      inValid = 1'b0;
      instr   = 16'h0;
      rsData  = 16'h0;
      rtData  = 16'h0;
      pc      = 16'h0;
      repeat (3) @(posedge clk);
      #1;
      arstN = 1'b1;
      finishTest("reset");

      for (int k = 0; k < 4; k++) begin
         sendRand(wordR(opArithR, 2'(k), r16()));
         sendRand(wordR(opArithR, 2'(k), r16()));
      end
      sendImmPair(opAddi);
      sendImmPair(opSubi);
      sendImmPair(opXori);
      sendImmPair(opAndni);
      sendRand(wordB(opLbi, 8'h35, r16()));
      sendRand(wordB(opLbi, 8'hc2, r16()));
      for (int k = 0; k < 20; k++) begin
         op = opAddi + 5'(k % 4);
         sendRand(wordI(op, 5'(r16()), r16()));
      end
      finishTest("alu arithmetic and logic");

      for (int k = 0; k < 4; k++) begin
         sendRand(wordR(opShiftR, 2'(k), r16()));
         sendRand(wordR(opShiftR, 2'(k), r16()));
         op = opRoli + 5'(k);
         sendImmPair(op);
         for (int n = 0; n < 6; n++) begin
            sendRand(wordI(op, 5'(r16()), r16()));
         end
      end
      finishTest("shifts and rotates");

      // Each branch with rs zero, positive and negative
      for (int k = 0; k < 4; k++) begin
         op = opBeqz + 5'(k);
         issue(wordB(op, 8'(r16()), r16()), 16'h0000, r16(), r16(), 1'b1);
         issue(wordB(op, 8'(r16()), r16()), {1'b0, 15'(r16())} | 16'h0001,
               r16(), r16(), 1'b1);
         issue(wordB(op, 8'(r16()), r16()), {1'b1, 15'(r16())}, r16(), r16(), 1'b1);
      end
      issue(wordJ(opHalt, 11'(r16())), 16'h0000, r16(), r16(), 1'b1);
      sendRand(wordJ(opHalt, 11'(r16())));
      finishTest("branches and halt");

      sendRand(wordJ(opJ, 11'h01f));
      sendRand(wordJ(opJ, 11'h7e0));
      sendRand(wordB(opJr, 8'h12, r16()));
      sendRand(wordB(opJr, 8'hf0, r16()));
      sendImmPair(opLd);
      sendImmPair(opSt);
      sendRand(wordJ(opNop, 11'(r16())));
      finishTest("jumps and memory");

      // Mostly defined opcodes, some fully random words
      for (int k = 0; k < 300; k++) begin
         if (($random(seed) & 3) == 0) begin
            word = r16();
         end else begin
            pick = ($random(seed) & 32'h7fff_ffff) % 21;
            word = {opList[pick], 11'(r16())};
         end
         issue(word, r16(), r16(), r16(), ($random(seed) % 3) != 0);
      end
      finishTest("random with bubbles");

      $display("Summary: %0d tests ok, %0d tests bad, %0d check errors",
               passCount, failCount, errCount);
      if (failCount == 0 && errCount == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
design/execPkg.sv
design/execCtrlIf.sv
design/claAdder16.sv
design/alu.sv
design/branchCond.sv
design/instrDecoder.sv
design/executeStage.sv
design/execTop.sv
verif/tbExec.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tbExec
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass only if the simulation prints the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x "ALL TESTS PASSED" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
